//--- filelist.f
+incdir+common
common/acq_pkg.sv
self_trigger/pulse_discriminator.sv
circ_buf/sample_ring.sv
circ_buf/trig_fifo.sv
logic/window_counter.sv
logic/acq_ctrl_fsm.sv
logic/event_packer.sv
logic/adc_acq_top.sv
verification/adc_acq_props.sv
verification/adc_acq_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the acquisition testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f \
  --top-module adc_acq_tb -o adc_acq_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/adc_acq_sim > sim.log 2>&1 || { echo "simulation run failed"; exit 1; }

grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

//--- verification/adc_acq_tb.sv
`timescale 1ns/1ps
`include "acq_cfg.svh"

module adc_acq_tb import acq_pkg::*;;

  localparam int TMO      = 200;   // cycles per wait
  localparam int THR      = 100;
  localparam int PRE      = 4;
  localparam int NUM      = 12;
  localparam int LOG_SIZE = 16384;

  logic adc_clk, arst_n, reset_timer, enable_triggering;
  adc_sample_t adc_data;
  logic [11:0] threshold;
  logic [9:0] pre_trig, num_samples;
  logic [3:0] channel_id;
  logic self_trig, acq_out_valid, acq_done, acq_sm_idle;
  acq_word_u acq_out_word;
  logic [15:0] waveform_num;

  adc_sample_t smp_log [LOG_SIZE];  // sample seen on each edge
  logic [41:0] ts_log [LOG_SIZE];    // timestamp seen on each edge
  int rst_cyc;                       // last edge that saw reset_timer high
  int trig_cyc;                      // last edge that saw self_trig
  int cyc;                           // edge index, updated late
  int err_cnt, strobe_cnt, done_cnt;
  int base;                          // baseline code
  logic [31:0] lfsr;
  acq_word_u word_q [$];             // captured output words
  int wcyc_q [$];                    // edge of each word

  adc_acq_top DUT (.*);

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  ////////////////////
  // sample log and output monitor
  always @(posedge adc_clk) begin
    smp_log[cyc % LOG_SIZE] = adc_data;
    ts_log[cyc % LOG_SIZE]  = 42'(cyc - rst_cyc - 1);  // edges since the timer release
    if (reset_timer) rst_cyc = cyc;
    if (acq_out_valid) begin
      word_q.push_back(acq_out_word);
      wcyc_q.push_back(cyc);
    end
    if (self_trig) trig_cyc = cyc;
    if (self_trig || acq_out_valid || acq_done) strobe_cnt++;
    if (acq_done) done_cnt++;
    cyc <= cyc + 1;  // tasks see the edge just taken
  end

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    repeat (n) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);  // galois step
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  task automatic check(input string name, input string what, input logic [63:0] exp,
                       input logic [63:0] act);
    assert (exp === act) else begin
      err_cnt++;
      $display("[ERROR] %s %s: expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  // one sample above baseline, returns the edge that samples it
  task automatic send_pulse(input int amp, input logic ovr, output int c);
    @(posedge adc_clk);
    adc_data <= '{ovr: ovr, sample: 12'(base + amp)};
    c = cyc + 1;
    @(posedge adc_clk);
    adc_data <= '{ovr: 1'b0, sample: 12'(base)};
  endtask

  task automatic next_word(input string name, output logic ok, output acq_word_u w,
                           output int wc);
    int t;
    t = 0;
    while (word_q.size() == 0 && t < TMO) begin
      @(posedge adc_clk);
      t++;
    end
    ok = (word_q.size() != 0);
    if (ok) begin
      w  = word_q.pop_front();
      wc = wcyc_q.pop_front();
    end else begin
      err_cnt++;
      $display("%s: timed out waiting for an output word", name);
    end
  endtask

  // header then NUM data words, expected from the sample log
  task automatic read_waveform(input string name, input int c, input int wfm);
    acq_word_u w;
    logic ok;
    int hc, wc;
    adc_sample_t exp_smp;
    next_word(name, ok, w, hc);
    if (!ok) return;
    check(name, "hdr kind", `ACQ_TAG_HDR, w.hdr.kind);
    check(name, "wfm num", wfm, w.hdr.wfm_num);
    check(name, "timestamp", ts_log[c % LOG_SIZE], w.hdr.ts);
    check(name, "channel", channel_id, w.hdr.chan_id);
    for (int k = 0; k < NUM; k++) begin
      next_word(name, ok, w, wc);
      if (!ok) return;
      exp_smp = smp_log[(c - PRE + k) % LOG_SIZE];  // pre samples then post samples
      check(name, "data cycle", hc + 1 + k, wc);
      check(name, "data kind", `ACQ_TAG_DAT, w.dat.kind);
      check(name, "index", k, w.dat.index);
      check(name, "pad", 0, w.dat.pad);
      check(name, "sample", exp_smp, w.dat.smp);
    end
  endtask

  ////////////////////
  // directed tests
  task automatic idle_after_reset();
    idle_cycles(20);
    check("reset", "idle", 1, acq_sm_idle);
    check("reset", "strobes", 0, strobe_cnt);
  endtask

  task automatic single_pulse();
    int amp, c;
    enable_triggering <= 1'b1;
    idle_cycles(24);  // pedestal fills
    amp = rand_bits(8);
    send_pulse(150 + amp, 1'b0, c);
    read_waveform("single", c, 0);
    check("single", "self_trig edge", c + 1, trig_cyc);  // one cycle after the crossing
  endtask

  task automatic threshold_equal();
    int c, t;
    idle_cycles(24);
    send_pulse(THR, 1'b0, c);
    t = 0;
    while (word_q.size() == 0 && t < 80) begin
      @(posedge adc_clk);
      t++;
    end
    check("equal", "words", 0, word_q.size());
  endtask

  task automatic close_pulses();
    int a1, a2, c1, c2;
    idle_cycles(24);
    a1 = rand_bits(8);
    a2 = rand_bits(8);
    send_pulse(150 + a1, 1'b0, c1);
    idle_cycles(4);  // second pulse lands inside the first window
    send_pulse(150 + a2, 1'b0, c2);
    read_waveform("double 1", c1, 1);
    read_waveform("double 2", c2, 2);
  endtask

  task automatic over_range_pulse();
    int amp, c;
    idle_cycles(24);
    amp = rand_bits(8);
    send_pulse(150 + amp, 1'b1, c);
    read_waveform("ovr", c, 3);  // ovr bit rides in data word PRE
  endtask

  task automatic disable_triggering();
    int t;
    enable_triggering <= 1'b0;
    t = 0;
    while (done_cnt == 0 && t < TMO) begin
      @(posedge adc_clk);
      t++;
    end
    if (done_cnt == 0) begin
      err_cnt++;
      $display("disable: acq_done never pulsed");
    end
    idle_cycles(5);
    check("disable", "done pulses", 1, done_cnt);
    check("disable", "idle", 1, acq_sm_idle);
    check("disable", "waveform num", 4, waveform_num);  // four headers so far
  endtask

  initial begin
    #200us;
    $display("simulation watchdog expired");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    lfsr = 32'h3eb2;
    cyc = 0;
    rst_cyc = -1;
    trig_cyc = -1;
    err_cnt = 0;
    strobe_cnt = 0;
    done_cnt = 0;
    base = rand_bits(8) + 300;
    arst_n = 1'b0;
    reset_timer = 1'b1;
    enable_triggering = 1'b0;
    adc_data = '{ovr: 1'b0, sample: 12'(base)};
    threshold = 12'(THR);
    pre_trig = 10'(PRE);
    num_samples = 10'(NUM);
    channel_id = 4'ha;
    repeat (16) @(posedge adc_clk);
    arst_n <= 1'b1;
    reset_timer <= 1'b0;
    idle_after_reset();
    single_pulse();
    threshold_equal();
    close_pulses();
    over_range_pulse();
    disable_triggering();
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verification/adc_acq_props.sv
`timescale 1ns/1ps
`include "acq_cfg.svh"

module adc_acq_props import acq_pkg::*; (
  input logic      adc_clk,
  input logic      arst_n,
  input logic      acq_out_valid,
  input logic      acq_sm_idle,
  input logic      trig_push,     // internal queue push
  input logic      rec_pop,       // internal queue pop
  input acq_word_u acq_out_word
);

  localparam int OCC_W = $clog2(`ACQ_FIFO_DEPTH) + 1;

  logic             is_hdr;  // header word on the output
  logic             is_dat;  // data word on the output
  logic [OCC_W-1:0] occ;     // records queued, counted from the strobes

  assign is_hdr = acq_out_valid && (acq_out_word.hdr.kind == `ACQ_TAG_HDR);
  assign is_dat = acq_out_valid && (acq_out_word.dat.kind == `ACQ_TAG_DAT);

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      occ <= '0;
    end else begin
      occ <= occ + OCC_W'(trig_push) - OCC_W'(rec_pop && (occ != '0));
    end
  end

  ////////////////////
  // output and queue rules
  idle_quiet: assert property (@(posedge adc_clk) disable iff (!arst_n)
    acq_sm_idle |-> !acq_out_valid)
    else $error("output strobe while the FSM is idle");

  no_push_full: assert property (@(posedge adc_clk) disable iff (!arst_n)
    (occ == OCC_W'(`ACQ_FIFO_DEPTH)) |-> !trig_push)
    else $error("trigger push into a full FIFO");

  hdr_then_dat: assert property (@(posedge adc_clk) disable iff (!arst_n)
    is_hdr |=> is_dat)
    else $error("header not followed by a data word");

endmodule

bind adc_acq_top adc_acq_props props (.*);

//--- logic/adc_acq_top.sv
`timescale 1ns/1ps
`include "acq_cfg.svh"

module adc_acq_top import acq_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     arst_n,
  input  adc_sample_t              adc_data,           // one sample per clock
  input  logic                     reset_timer,        // level, clears timestamp
  input  logic                     enable_triggering,
  input  logic [`ACQ_SAMPLE_W-1:0] threshold,
  input  logic [`ACQ_RING_AW-1:0]  pre_trig,
  input  logic [`ACQ_RING_AW-1:0]  num_samples,
  input  logic [`ACQ_CHAN_W-1:0]   channel_id,
  output logic                     self_trig,
  output acq_word_u                acq_out_word,
  output logic                     acq_out_valid,
  output logic                     acq_done,
  output logic                     acq_sm_idle,
  output logic [`ACQ_WFM_W-1:0]    waveform_num
);

  logic [`ACQ_RING_AW-1:0] wr_addr;     // ring write slot
  logic [`ACQ_RING_AW-1:0] rd_addr;     // ring read slot
  logic [`ACQ_RING_AW-1:0] win_index;
  adc_sample_t             rd_sample;
  trig_rec_t               trig_rec;    // from discriminator
  trig_rec_t               head_rec;    // queue head
  logic                    trig_push;
  logic                    rec_pop;
  logic                    fifo_empty;
  logic                    fifo_full;
  logic                    capture_en;
  logic                    win_start;
  logic                    hdr_emit;
  logic                    win_active;
  logic                    win_last;

  ////////////////////
  // trigger path
  pulse_discriminator pulse_discriminator (.adc_clk, .arst_n, .adc_data,
    .enable(enable_triggering), .reset_timer, .threshold, .wr_addr, .self_trig, .trig_rec);

  trig_fifo trig_fifo (.adc_clk, .arst_n, .push(trig_push), .rec_in(trig_rec),
    .pop(rec_pop), .head_rec, .fifo_empty, .fifo_full);

  acq_ctrl_fsm acq_ctrl_fsm (.adc_clk, .arst_n, .enable_triggering, .self_trig,
    .fifo_empty, .fifo_full, .win_last, .trig_push, .rec_pop, .win_start, .hdr_emit,
    .capture_en, .acq_done, .acq_sm_idle);

  ////////////////////
  // sample path
  sample_ring sample_ring (.adc_clk, .arst_n, .capture_en, .adc_data, .wr_addr,
    .rd_addr, .rd_sample);

  window_counter window_counter (.adc_clk, .arst_n, .win_start, .trig_addr(head_rec.addr),
    .pre_trig, .num_samples, .rd_addr, .win_active, .win_last, .win_index);

  event_packer event_packer (.adc_clk, .arst_n, .hdr_emit, .head_rec, .channel_id,
    .win_active, .win_index, .rd_sample, .acq_out_word, .acq_out_valid, .waveform_num);

endmodule

//--- logic/event_packer.sv
`timescale 1ns/1ps
`include "acq_cfg.svh"

module event_packer import acq_pkg::*; (
  input  logic                    adc_clk,
  input  logic                    arst_n,
  input  logic                    hdr_emit,
  input  trig_rec_t               head_rec,       // record being read out
  input  logic [`ACQ_CHAN_W-1:0]  channel_id,
  input  logic                    win_active,     // ring read issued this cycle
  input  logic [`ACQ_RING_AW-1:0] win_index,
  input  adc_sample_t             rd_sample,      // one cycle behind win_active
  output acq_word_u               acq_out_word,
  output logic                    acq_out_valid,  // one cycle per word
  output logic [`ACQ_WFM_W-1:0]   waveform_num    // number of the next header
);

  logic                    dat_act_q;  // rd_sample is a window sample
  logic [`ACQ_RING_AW-1:0] dat_idx_q;  // index lined up with rd_sample

  ////////////////////
  // control and strobe
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      dat_act_q     <= 1'b0;
      acq_out_valid <= 1'b0;
      waveform_num  <= '0;
    end else begin
      dat_act_q     <= win_active;
      acq_out_valid <= hdr_emit || dat_act_q;
      if (hdr_emit) begin
        waveform_num <= waveform_num + 1'b1;
      end
    end
  end

  ////////////////////
  // word payload
  always_ff @(posedge adc_clk) begin
    dat_idx_q <= win_index;
    if (hdr_emit) begin
      acq_out_word.hdr <= '{kind:    `ACQ_TAG_HDR,
                            wfm_num: waveform_num,
                            ts:      head_rec.ts,
                            chan_id: channel_id};
    end else if (dat_act_q) begin
      acq_out_word.dat <= '{kind:  `ACQ_TAG_DAT,
                            index: DAT_IDX_W'(dat_idx_q),  // zero extended
                            pad:   '0,
                            smp:   rd_sample};
    end
  end

endmodule

//--- logic/acq_ctrl_fsm.sv
`timescale 1ns/1ps

module acq_ctrl_fsm import acq_pkg::*; (
  input  logic adc_clk,
  input  logic arst_n,
  input  logic enable_triggering,
  input  logic self_trig,          // strobe from the discriminator
  input  logic fifo_empty,
  input  logic fifo_full,
  input  logic win_last,
  output logic trig_push,          // queue the current trigger record
  output logic rec_pop,            // head record consumed
  output logic win_start,          // load the window counter
  output logic hdr_emit,           // build the header word
  output logic capture_en,         // ring keeps writing
  output logic acq_done,           // one cycle on the way to idle
  output logic acq_sm_idle
);

  typedef enum logic [2:0] {
    IDLE,
    ARMED,    // waiting for a queued record
    HEADER,   // first window cycle
    READOUT,  // rest of the window
    GAP       // spacing before the next header
  } state_t;

  state_t state;
  state_t state_nxt;

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    win_start = 1'b0;
    hdr_emit  = 1'b0;
    rec_pop   = 1'b0;
    acq_done  = 1'b0;
    case (state)
      IDLE: begin
        if (enable_triggering) state_nxt = ARMED;
      end
      ARMED: begin
        if (!fifo_empty) begin
          win_start = 1'b1;  // head record is already visible
          state_nxt = HEADER;
        end else if (!enable_triggering && !self_trig) begin
          acq_done  = 1'b1;  // nothing queued and nothing in flight
          state_nxt = IDLE;
        end
      end
      HEADER: begin
        hdr_emit  = 1'b1;
        rec_pop   = 1'b1;  // record is read this cycle then dropped
        state_nxt = win_last ? GAP : READOUT;
      end
      READOUT: begin
        if (win_last) state_nxt = GAP;
      end
      GAP:     state_nxt = ARMED;
      default: state_nxt = IDLE;
    endcase
  end

  assign capture_en  = (state != IDLE);                       // armed or reading out
  assign trig_push   = self_trig && capture_en && !fifo_full;  // otherwise lost
  assign acq_sm_idle = (state == IDLE);

endmodule

//--- logic/window_counter.sv
`timescale 1ns/1ps
`include "acq_cfg.svh"

module window_counter import acq_pkg::*; (
  input  logic                    adc_clk,
  input  logic                    arst_n,
  input  logic                    win_start,    // load a new window
  input  logic [`ACQ_RING_AW-1:0] trig_addr,    // ring slot of the crossing sample
  input  logic [`ACQ_RING_AW-1:0] pre_trig,     // samples before the crossing
  input  logic [`ACQ_RING_AW-1:0] num_samples,  // window length, zero reads as 1024
  output logic [`ACQ_RING_AW-1:0] rd_addr,
  output logic                    win_active,   // rd_addr is a window sample
  output logic                    win_last,     // last sample of the window
  output logic [`ACQ_RING_AW-1:0] win_index     // position inside the window
);

  assign win_last = win_active && (win_index == num_samples - 1'b1);

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_addr    <= '0;
      win_index  <= '0;
      win_active <= 1'b0;
    end else if (win_start) begin
      rd_addr    <= trig_addr - pre_trig;  // wraps around the ring
      win_index  <= '0;
      win_active <= 1'b1;
    end else if (win_active) begin
      rd_addr   <= rd_addr + 1'b1;
      win_index <= win_index + 1'b1;
      if (win_last) begin
        win_active <= 1'b0;
      end
    end
  end

endmodule

//--- circ_buf/trig_fifo.sv
`timescale 1ns/1ps
`include "acq_cfg.svh"

module trig_fifo import acq_pkg::*; (
  input  logic      adc_clk,
  input  logic      arst_n,
  input  logic      push,
  input  trig_rec_t rec_in,
  input  logic      pop,
  output trig_rec_t head_rec,    // show-ahead head entry
  output logic      fifo_empty,
  output logic      fifo_full
);

  localparam int DEPTH = `ACQ_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  trig_rec_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;  // entries held
  logic             do_push;
  logic             do_pop;

  assign do_push    = push && !fifo_full;   // push when full is dropped
  assign do_pop     = pop && !fifo_empty;
  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == DEPTH[PTR_W:0]);
  assign head_rec   = mem[rd_ptr];

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // power of two depth wraps by itself
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
    end
  end

  always_ff @(posedge adc_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= rec_in;
    end
  end

endmodule

//--- circ_buf/sample_ring.sv
`timescale 1ns/1ps
`include "acq_cfg.svh"

module sample_ring import acq_pkg::*; (
  input  logic                    adc_clk,
  input  logic                    arst_n,
  input  logic                    capture_en,  // write one sample per cycle
  input  adc_sample_t             adc_data,
  output logic [`ACQ_RING_AW-1:0] wr_addr,     // slot written on the next edge
  input  logic [`ACQ_RING_AW-1:0] rd_addr,
  output adc_sample_t             rd_sample    // one cycle after rd_addr
);

  localparam int DEPTH = 1 << `ACQ_RING_AW;

  adc_sample_t mem [DEPTH];  // circular sample store

  ////////////////////
  // write side
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_addr <= '0;
    end else if (capture_en) begin
      wr_addr <= wr_addr + 1'b1;  // wraps at DEPTH
    end
  end

  always_ff @(posedge adc_clk) begin
    if (capture_en) begin
      mem[wr_addr] <= adc_data;
    end
  end

  ////////////////////
  // read side
  always_ff @(posedge adc_clk) begin
    rd_sample <= mem[rd_addr];  // old data on a same-slot write
  end

endmodule

//--- self_trigger/pulse_discriminator.sv
`timescale 1ns/1ps
`include "acq_cfg.svh"

module pulse_discriminator import acq_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     arst_n,
  input  adc_sample_t              adc_data,     // sample on this edge
  input  logic                     enable,       // look for triggers
  input  logic                     reset_timer,  // holds the timestamp at zero
  input  logic [`ACQ_SAMPLE_W-1:0] threshold,    // required excess over pedestal
  input  logic [`ACQ_RING_AW-1:0]  wr_addr,      // ring slot written on this edge
  output logic                     self_trig,    // one cycle after the crossing edge
  output trig_rec_t                trig_rec      // valid with self_trig
);

  localparam int PED_N = 1 << `ACQ_PED_LOG2;
  localparam int SUM_W = `ACQ_SAMPLE_W + `ACQ_PED_LOG2;

  logic [`ACQ_SAMPLE_W-1:0]     hist [PED_N];  // previous samples, [0] newest
  logic [SUM_W-1:0]             ped_sum;       // running sum of hist
  logic [`ACQ_PED_LOG2:0]       fill_cnt;      // samples taken since enable
  logic                         ready;
  logic [`ACQ_SAMPLE_W-1:0]     pedestal;
  logic signed [`ACQ_SAMPLE_W:0] excess;
  logic                         above;
  logic                         above_q;       // previous sample was above
  logic                         fire;
  logic [`ACQ_TS_W-1:0]         ts_cnt;

  ////////////////////
  // boxcar pedestal
  assign ready    = fill_cnt[`ACQ_PED_LOG2];             // 16 samples in history
  assign pedestal = ped_sum[SUM_W-1:`ACQ_PED_LOG2];      // sum / 16
  assign excess   = $signed({1'b0, adc_data.sample}) - $signed({1'b0, pedestal});
  assign above    = excess > $signed({1'b0, threshold}); // equal is not enough
  assign fire     = enable && ready && above && !above_q; // rising crossing only

  always_ff @(posedge adc_clk) begin
    if (enable) begin
      hist[0] <= adc_data.sample;
      for (int i = 1; i < PED_N; i++) begin
        hist[i] <= hist[i-1];  // oldest falls off the end
      end
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      ped_sum  <= '0;
      fill_cnt <= '0;
      above_q  <= 1'b0;
    end else if (!enable) begin
      ped_sum  <= '0;  // restart the fill when re-enabled
      fill_cnt <= '0;
      above_q  <= 1'b0;
    end else begin
      above_q <= above;
      if (ready) begin
        ped_sum <= ped_sum + SUM_W'(adc_data.sample) - SUM_W'(hist[PED_N-1]);
      end else begin
        ped_sum  <= ped_sum + SUM_W'(adc_data.sample);  // history still filling
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // timestamp and record
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      ts_cnt    <= '0;
      self_trig <= 1'b0;
    end else begin
      ts_cnt    <= reset_timer ? '0 : ts_cnt + 1'b1;  // free running
      self_trig <= fire;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (fire) begin
      trig_rec <= '{addr: wr_addr, ts: ts_cnt};  // counter value at the crossing edge
    end
  end

endmodule

//--- common/acq_pkg.sv
package acq_pkg;

  `include "acq_cfg.svh"

  ////////////////////
  // sample as it leaves the adc
  typedef struct packed {
    logic                     ovr;     // over-range flag
    logic [`ACQ_SAMPLE_W-1:0] sample;  // raw code
  } adc_sample_t;

  ////////////////////
  // one queued trigger
  typedef struct packed {
    logic [`ACQ_RING_AW-1:0] addr;  // ring slot of the crossing sample
    logic [`ACQ_TS_W-1:0]    ts;    // counter value at the crossing edge
  } trig_rec_t;

  localparam int DAT_IDX_W = 16;  // sample index field in data view
  localparam int DAT_PAD_W = `ACQ_WORD_W - 2 - DAT_IDX_W - $bits(adc_sample_t);

  // header view of a readout word
  typedef struct packed {
    logic [1:0]            kind;     // ACQ_TAG_HDR
    logic [`ACQ_WFM_W-1:0] wfm_num;  // counts headers from zero
    logic [`ACQ_TS_W-1:0]  ts;       // trigger time
    logic [`ACQ_CHAN_W-1:0] chan_id;
  } hdr_view_t;

  // data view of a readout word
  typedef struct packed {
    logic [1:0]           kind;   // ACQ_TAG_DAT
    logic [DAT_IDX_W-1:0] index;  // position inside the window
    logic [DAT_PAD_W-1:0] pad;    // always zero
    adc_sample_t          smp;    // sample with its over-range bit
  } dat_view_t;

  // the kind field sits at the top of both views
  typedef union packed {
    hdr_view_t hdr;
    dat_view_t dat;
  } acq_word_u;

endpackage

//--- common/acq_cfg.svh
`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

////////////////////
// datapath widths
`define ACQ_SAMPLE_W   12     // adc sample bits
`define ACQ_RING_AW    10     // ring address bits, 1024 samples
`define ACQ_TS_W       42     // timestamp counter bits
`define ACQ_WORD_W     64     // readout word bits
`define ACQ_WFM_W      16     // waveform number bits in header
`define ACQ_CHAN_W     4      // channel id bits in header

////////////////////
// trigger and queue
`define ACQ_PED_LOG2   4      // boxcar length is 2**4 samples
`define ACQ_FIFO_DEPTH 4      // queued trigger records

////////////////////
// word kind codes
`define ACQ_TAG_HDR    2'b01  // header word
`define ACQ_TAG_DAT    2'b10  // data word

`endif
